//--- list.f
src/board_pkg.sv
src/tm_display_if.sv
src/slow_clk_gen.sv
src/mic3_spi_receiver.sv
src/tm1638_board_controller.sv
src/lab_top.sv
src/board_top.sv
tests/tb_board_top.sv

//--- src/board_pkg.sv
package board_pkg;

    // board side widths, also the defaults of the top level parameters
    parameter int w_key = 4;
    parameter int w_sw  = 4;
    parameter int w_led = 4;

    // the TM1638 module always has eight of each
    parameter int w_tm_key   = 8;
    parameter int w_tm_led   = 8;
    parameter int w_tm_digit = 8;

    parameter int w_mic = 12;  // PMOD MIC3 sample width

    // command bytes of the TM1638, sent LSB first
    typedef enum logic [7:0]
    {
        cmd_write_auto = 8'h40,  // data write with address auto increment
        cmd_read_keys  = 8'h42,  // key scan read
        cmd_addr_zero  = 8'hc0,  // set address to 0
        cmd_display_on = 8'h8f   // display on at full brightness
    } tm_cmd_t;

    // one step per command frame of a refresh
    typedef enum logic [2:0]
    {
        st_write_cmd,
        st_addr,
        st_data,
        st_bright,
        st_read_cmd,
        st_read_keys,
        st_gap
    } tm_state_t;

endpackage

//--- src/board_top.sv
`timescale 1ns/10ps

module board_top
#(
    parameter clk_mhz     = 100,
    parameter slow_clk_hz = 1,
    parameter w_key       = board_pkg::w_key,
    parameter w_sw        = board_pkg::w_sw,
    parameter w_led       = board_pkg::w_led
)
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic [w_key - 1:0] key,
    input  logic [w_sw  - 1:0] sw,
    output logic [w_led - 1:0] led,
    output logic               tm_sio_clk,
    output logic               tm_sio_stb,
    inout  wire                tm_sio_data,
    output logic               mic_cs,
    output logic               mic_sck,
    input  logic               mic_sdo
);
    import board_pkg::*;

    tm_display_if tm_bus ();

    logic                          slow_clk;
    logic [w_mic - 1:0]            mic_value;
    logic [w_key + w_tm_key - 1:0] lab_key;

    assign lab_key = {tm_bus.keys, key};  // module keys sit above the board keys

    slow_clk_gen #(.clk_mhz(clk_mhz), .slow_clk_hz(slow_clk_hz)) i_slow_clk_gen
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .slow_clk (slow_clk)
    );

    mic3_spi_receiver #(.clk_mhz(clk_mhz)) i_mic
    (
        .clk    (clk),
        .arst_n (arst_n),
        .cs     (mic_cs),
        .sck    (mic_sck),
        .sdo    (mic_sdo),
        .value  (mic_value)
    );

    lab_top #(.w_key(w_key), .w_sw(w_sw), .w_led(w_led)) i_lab_top
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .slow_clk  (slow_clk),
        .lab_key   (lab_key),
        .sw        (sw),
        .led       (led),
        .mic_value (mic_value),
        .disp      (tm_bus.lab)
    );

    tm1638_board_controller #(.clk_mhz(clk_mhz)) i_ledkey
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .disp     (tm_bus.ctrl),
        .sio_clk  (tm_sio_clk),
        .sio_stb  (tm_sio_stb),
        .sio_data (tm_sio_data)
    );

endmodule

//--- src/lab_top.sv
`timescale 1ns/10ps

module lab_top
#(
    parameter w_key = 4,
    parameter w_sw  = 4,
    parameter w_led = 4
)
(
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     slow_clk,
    input  logic [w_key + board_pkg::w_tm_key - 1:0] lab_key,
    input  logic [w_sw - 1:0]                        sw,
    output logic [w_led - 1:0]                       led,
    input  logic [board_pkg::w_mic - 1:0]            mic_value,
    tm_display_if.lab                                disp
);
    import board_pkg::*;

    localparam int w_lab_key = w_key + w_tm_key;

    logic [w_lab_key - 1:0] key_prev;
    logic [w_lab_key - 1:0] pressed_new;
    logic [3:0]             new_idx;
    logic [3:0]             key_idx;  // one hex digit of key index
    logic [w_mic - 1:0]     sample;
    logic [2:0]             scan;
    logic [7:0]             seg;

    function automatic logic [7:0] hex_seg(input logic [3:0] nib);
        case (nib)  // abcdefg followed by the decimal point
            4'h0:    hex_seg = 8'b1111_1100;
            4'h1:    hex_seg = 8'b0110_0000;
            4'h2:    hex_seg = 8'b1101_1010;
            4'h3:    hex_seg = 8'b1111_0010;
            4'h4:    hex_seg = 8'b0110_0110;
            4'h5:    hex_seg = 8'b1011_0110;
            4'h6:    hex_seg = 8'b1011_1110;
            4'h7:    hex_seg = 8'b1110_0000;
            4'h8:    hex_seg = 8'b1111_1110;
            4'h9:    hex_seg = 8'b1111_0110;
            4'ha:    hex_seg = 8'b1110_1110;
            4'hb:    hex_seg = 8'b0011_1110;
            4'hc:    hex_seg = 8'b1001_1100;
            4'hd:    hex_seg = 8'b0111_1010;
            4'he:    hex_seg = 8'b1001_1110;
            default: hex_seg = 8'b1000_1110;
        endcase
    endfunction

    assign pressed_new = lab_key & ~key_prev;

    // lowest key that went down this cycle
    always_comb
    begin
        new_idx = '0;
        for (int i = w_lab_key - 1; i >= 0; i--)
            if (pressed_new[i])
                new_idx = 4'(i);
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            key_prev <= '0;
            key_idx  <= '0;
            sample   <= '0;
            scan     <= '0;
            led      <= '0;
        end
        else
        begin
            key_prev <= lab_key;
            scan     <= scan + 3'd1;  // one digit per cycle
            led      <= w_led'(sw);
            if (|pressed_new)
            begin
                sample  <= mic_value;
                key_idx <= new_idx;
            end
        end
    end

    always_comb
    begin
        case (scan)
            3'd0:    seg = hex_seg(sample[3:0]);
            3'd1:    seg = hex_seg(sample[7:4]);
            3'd2:    seg = hex_seg(sample[11:8]);
            3'd7:    seg = hex_seg(key_idx) | {7'b0, slow_clk};  // blinking point
            default: seg = '0;
        endcase

        for (int i = 0; i < w_tm_led; i++)
            disp.led[i] = (3'(i) < sample[w_mic - 1 -: 3]);  // thermometer from LED 0
    end

    assign disp.hgfedcba = seg;
    assign disp.digit    = w_tm_digit'(1) << scan;

endmodule

//--- src/mic3_spi_receiver.sv
`timescale 1ns/10ps

module mic3_spi_receiver
#(
    parameter clk_mhz = 100
)
(
    input  logic                          clk,
    input  logic                          arst_n,
    output logic                          cs,
    output logic                          sck,
    input  logic                          sdo,
    output logic [board_pkg::w_mic - 1:0] value
);
    import board_pkg::*;

    localparam int half_raw    = clk_mhz / 8;
    localparam int half_period = half_raw < 1 ? 1 : half_raw;  // clk cycles per sck half period
    localparam int w_div       = half_period > 1 ? $clog2(half_period) : 1;

    // steps 0..31 are the 16 sck cycles with cs low, 32..39 the idle time
    localparam logic [5:0] last_step = 6'd39;

    logic [w_div - 1:0] div_cnt;
    logic               tick;
    logic [5:0]         step;
    logic [5:0]         step_next;
    logic [w_mic - 1:0] shift;

    assign tick      = (div_cnt == w_div'(half_period - 1));
    assign step_next = (step == last_step) ? 6'd0 : step + 6'd1;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt <= '0;
            step    <= 6'd32;  // start with an idle gap
            cs      <= 1'b1;
            sck     <= 1'b1;
            shift   <= '0;
            value   <= '0;
        end
        else if (tick)
        begin
            div_cnt <= '0;
            step    <= step_next;
            cs      <= step_next[5];
            sck     <= step_next[5] | step_next[0];  // low on even steps inside the frame

            // sck rises on this tick, sdo was set on the previous falling edge
            if (!step[5] && !step[0])
                shift <= {shift[w_mic - 2:0], sdo};  // the four leading zeros fall out the top

            if (step == 6'd31)
                value <= shift;  // cs rises together with the update
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

endmodule

//--- src/slow_clk_gen.sv
`timescale 1ns/10ps

module slow_clk_gen
#(
    parameter clk_mhz     = 100,
    parameter slow_clk_hz = 1
)
(
    input  logic clk,
    input  logic arst_n,
    output logic slow_clk
);

    localparam int half_raw    = clk_mhz * 500000 / slow_clk_hz;
    localparam int half_period = half_raw < 1 ? 1 : half_raw;  // clk cycles per slow half period
    localparam int w_cnt       = half_period > 1 ? $clog2(half_period) : 1;

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cnt      <= '0;
            slow_clk <= 1'b0;
        end
        else if (cnt == w_cnt'(half_period - 1))
        begin
            cnt      <= '0;
            slow_clk <= ~slow_clk;  // toggle once per half period
        end
        else
            cnt <= cnt + 1'b1;
    end

endmodule

//--- src/tm1638_board_controller.sv
`timescale 1ns/10ps

module tm1638_board_controller
#(
    parameter clk_mhz = 100
)
(
    input  logic       clk,
    input  logic       arst_n,
    tm_display_if.ctrl disp,
    output logic       sio_clk,
    output logic       sio_stb,
    inout  wire        sio_data
);
    import board_pkg::*;

    localparam int half_raw    = clk_mhz / 4;
    localparam int half_period = half_raw < 1 ? 1 : half_raw;  // clk cycles per sio_clk half period
    localparam int w_div       = half_period > 1 ? $clog2(half_period) : 1;

    logic [w_tm_digit - 1:0] seg_mem [0:w_tm_digit - 1];
    logic [w_div - 1:0]      div_cnt;
    logic                    tick;
    tm_state_t               state;
    tm_state_t               next_frame;
    tm_cmd_t                 cmd_byte;
    logic                    active;   // sio_stb is low
    logic                    ending;   // last byte sent, raise sio_stb next
    logic                    half;     // high half of the bit comes next
    logic                    oe;
    logic                    dout;
    logic [2:0]              bit_cnt;
    logic [3:0]              byte_cnt;
    logic [3:0]              load_idx;
    logic [7:0]              data_byte;
    logic [7:0]              shifter;
    logic [7:0]              rx;
    logic [7:0]              rx_byte;
    logic [w_tm_key - 1:0]   key_acc;
    logic [w_tm_key - 1:0]   keys_q;

    // the lab block scans one digit per cycle
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < w_tm_digit; i++)
            if (disp.digit[i])
                seg_mem[i] <= disp.hgfedcba;
    end

    assign tick      = (div_cnt == w_div'(half_period - 1));
    assign sio_data  = oe ? dout : 1'bz;
    assign disp.keys = keys_q;
    assign rx_byte   = {sio_data, rx[7:1]};  // byte including the bit sampled now

    // even bytes are segments, odd bytes carry one LED in bit 0
    assign load_idx  = (state == st_data) ? byte_cnt + 4'd1 : 4'd0;
    assign data_byte = load_idx[0] ? {7'b0, disp.led[load_idx[3:1]]} : seg_mem[load_idx[3:1]];

    always_comb
    begin
        case (state)
            st_addr:     cmd_byte = cmd_addr_zero;
            st_bright:   cmd_byte = cmd_display_on;
            st_read_cmd: cmd_byte = cmd_read_keys;
            default:     cmd_byte = cmd_write_auto;
        endcase

        case (state)
            st_write_cmd: next_frame = st_addr;
            st_data:      next_frame = st_bright;
            st_bright:    next_frame = st_read_cmd;
            default:      next_frame = st_gap;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt  <= '0;
            state    <= st_write_cmd;
            active   <= 1'b0;
            ending   <= 1'b0;
            half     <= 1'b0;
            oe       <= 1'b1;
            dout     <= 1'b0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            shifter  <= '0;
            rx       <= '0;
            key_acc  <= '0;
            keys_q   <= '0;
            sio_clk  <= 1'b1;
            sio_stb  <= 1'b1;
        end
        else if (!tick)
            div_cnt <= div_cnt + 1'b1;
        else
        begin
            div_cnt <= '0;

            if (!active)
            begin
                if (state == st_gap)
                begin
                    byte_cnt <= byte_cnt + 4'd1;
                    if (byte_cnt == 4'd15)
                        state <= st_write_cmd;  // pause over, start the next refresh
                end
                else
                begin
                    sio_stb <= 1'b0;
                    active  <= 1'b1;
                    shifter <= cmd_byte;
                    bit_cnt <= '0;
                    half    <= 1'b0;
                end
            end
            else if (ending)
            begin
                sio_stb  <= 1'b1;
                active   <= 1'b0;
                ending   <= 1'b0;
                oe       <= 1'b1;
                byte_cnt <= '0;
                state    <= next_frame;
            end
            else if (!half)
            begin
                sio_clk <= 1'b0;
                dout    <= shifter[0];  // data changes while sio_clk is low
                half    <= 1'b1;
            end
            else
            begin
                sio_clk <= 1'b1;
                half    <= 1'b0;
                shifter <= shifter >> 1;
                rx      <= rx_byte;
                bit_cnt <= bit_cnt + 3'd1;

                if (bit_cnt == 3'd7)
                begin
                    case (state)
                        st_addr:
                        begin
                            state    <= st_data;  // same frame continues with the data
                            byte_cnt <= '0;
                            shifter  <= data_byte;
                        end
                        st_data:
                        begin
                            if (byte_cnt == 4'd15)
                                ending <= 1'b1;
                            else
                            begin
                                byte_cnt <= byte_cnt + 4'd1;
                                shifter  <= data_byte;
                            end
                        end
                        st_read_cmd:
                        begin
                            state    <= st_read_keys;
                            byte_cnt <= '0;
                            oe       <= 1'b0;  // the module drives sio_data now
                        end
                        st_read_keys:
                        begin
                            // keys 2k and 2k+1 sit in bits 0 and 4 of byte k
                            key_acc <= {rx_byte[4], rx_byte[0], key_acc[w_tm_key - 1:2]};
                            if (byte_cnt == 4'd3)
                            begin
                                keys_q <= {rx_byte[4], rx_byte[0], key_acc[w_tm_key - 1:2]};
                                ending <= 1'b1;
                            end
                            else
                                byte_cnt <= byte_cnt + 4'd1;
                        end
                        default:
                            ending <= 1'b1;  // single byte commands
                    endcase
                end
            end
        end
    end

endmodule

//--- src/tm_display_if.sv
`timescale 1ns/10ps

interface tm_display_if;
    import board_pkg::*;

    logic [w_tm_digit - 1:0] hgfedcba;  // bit 7 is segment a, bit 0 the decimal point
    logic [w_tm_digit - 1:0] digit;     // one-hot digit select
    logic [w_tm_led   - 1:0] led;
    logic [w_tm_key   - 1:0] keys;

    modport lab
    (
        output hgfedcba,
        output digit,
        output led,
        input  keys
    );

    modport ctrl
    (
        input  hgfedcba,
        input  digit,
        input  led,
        output keys
    );

endinterface

//--- tests/tb_board_top.sv
`timescale 1ns/10ps

module tb_board_top;
    import board_pkg::*;

    typedef logic [15:0][w_tm_digit - 1:0] image_t;  // byte 2i is digit i, byte 2i+1 is LED i

    // abcdefg patterns of the hex digits, F down to 0
    localparam logic [15:0][6:0] seg_table = {7'h47, 7'h4f, 7'h3d, 7'h4e, 7'h1f, 7'h77, 7'h7b,
        7'h7f, 7'h70, 7'h5f, 7'h5b, 7'h33, 7'h79, 7'h6d, 7'h30, 7'h7e};

    logic               clk;
    logic               arst_n;
    logic [w_key - 1:0] key;
    logic [w_sw  - 1:0] sw;
    logic [w_led - 1:0] led;
    logic               tm_sio_clk;
    logic               tm_sio_stb;
    wire                tm_sio_data;
    logic               mic_cs;
    logic               mic_sck;
    logic               mic_sdo;

    logic                  md_oe;       // the module model drives sio_data
    logic                  md_val;
    logic [7:0]            cur_byte;
    int                    frame_bits;
    tm_cmd_t               frame_cmd;
    tm_cmd_t               cmd_log [$];  // first commands after reset
    image_t                img_work;
    image_t                image;        // last complete display write
    int                    image_count;
    logic [w_tm_key - 1:0] tm_keys;
    logic [w_mic - 1:0]    mic_sample;
    int                    mic_bit;
    int                    mic_frames;
    int                    seed;
    int                    n;
    logic [w_mic - 1:0]    cur_sample;
    logic [3:0]            cur_idx;
    logic [w_sw - 1:0]     sw_val;
    bit                    seen_dp0;
    bit                    seen_dp1;

    assign tm_sio_data = md_oe ? md_val : 1'bz;

    board_top #(.clk_mhz(4), .slow_clk_hz(50000)) board_top_inst
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .key         (key),
        .sw          (sw),
        .led         (led),
        .tm_sio_clk  (tm_sio_clk),
        .tm_sio_stb  (tm_sio_stb),
        .tm_sio_data (tm_sio_data),
        .mic_cs      (mic_cs),
        .mic_sck     (mic_sck),
        .mic_sdo     (mic_sdo)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // the TM1638 model takes bytes LSB first on the rising sio_clk
    always @(posedge tm_sio_clk)
    begin
        if (!tm_sio_stb)
        begin
            cur_byte   = {tm_sio_data, cur_byte[7:1]};
            frame_bits = frame_bits + 1;
            if (frame_bits % 8 == 0)
            begin
                if (frame_bits == 8)
                begin
                    frame_cmd = tm_cmd_t'(cur_byte);
                    if (cmd_log.size() < 4)
                        cmd_log.push_back(frame_cmd);
                end
                else if (frame_cmd == cmd_addr_zero && frame_bits <= 136)
                    img_work[frame_bits / 8 - 2] = cur_byte;
            end
        end
    end

    // key bits go out while sio_clk is low with key 2k in bit 0 and key 2k+1 in bit 4 of byte k
    always @(negedge tm_sio_clk)
    begin
        if (!tm_sio_stb && frame_cmd == cmd_read_keys && frame_bits >= 8)
        begin
            md_oe = 1'b1;
            case ((frame_bits - 8) % 8)
                0:       md_val = tm_keys[2 * ((frame_bits - 8) / 8)];
                4:       md_val = tm_keys[2 * ((frame_bits - 8) / 8) + 1];
                default: md_val = 1'b0;
            endcase
        end
    end

    always @(negedge tm_sio_stb)
        frame_bits = 0;

    always @(posedge tm_sio_stb)
    begin
        md_oe = 1'b0;
        if (frame_cmd == cmd_addr_zero && frame_bits == 136)
        begin
            image       = img_work;
            image_count = image_count + 1;
        end
    end

    // the MIC3 model sends four zeros and then the sample MSB first on the falling sck
    always @(negedge mic_sck)
    begin
        if (mic_bit < 16)
            mic_sdo = mic_bit < 4 ? 1'b0 : mic_sample[15 - mic_bit];
        mic_bit = mic_bit + 1;
    end

    always @(posedge mic_cs)
    begin
        mic_bit    = 0;
        mic_frames = mic_frames + 1;
    end

    function automatic image_t expected_image(input logic [w_mic - 1:0] smp,
                                              input logic [3:0] idx, input logic dp);
        image_t     img;
        logic [2:0] lit;
        lit = smp[w_mic - 1 -: 3];
        for (int i = 0; i < w_tm_digit; i++)
        begin
            img[2 * i]     = '0;
            img[2 * i + 1] = {7'b0, i < lit};  // thermometer from LED 0
        end
        img[0]  = {seg_table[smp[3:0]], 1'b0};
        img[2]  = {seg_table[smp[7:4]], 1'b0};
        img[4]  = {seg_table[smp[11:8]], 1'b0};
        img[14] = {seg_table[idx], dp};
        return img;
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic step_cycles(input int cycles);
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    task automatic check_image(input string name, input image_t exp, input image_t act);
        if (exp !== act)
            stop_run($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_leds(input string name, input logic [w_led - 1:0] exp,
                              input logic [w_led - 1:0] act);
        if (exp !== act)
            stop_run($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_cmd(input string name, input tm_cmd_t exp, input tm_cmd_t act);
        if (exp !== act)
            stop_run($sformatf("FAILED %s expected %h (%s) actual %h (%s)",
                               name, exp, exp.name(), act, act.name()));
    endtask

    task automatic check_pin(input string name, input logic exp, input logic act);
        if (exp !== act)
            stop_run($sformatf("FAILED %s expected %b actual %b", name, exp, act));
    endtask

    task automatic wait_cmds(input int count);
        int cycles;
        cycles = 0;
        while (cmd_log.size() < count)
        begin
            if (cycles == 2000)
                stop_run("timeout waiting for the first TM1638 commands after reset");
            @(posedge clk);
            cycles++;
        end
        #1;
    endtask

    task automatic wait_refreshes(input int count);
        int target;
        int cycles;
        target = image_count + count;
        cycles = 0;
        while (image_count < target)
        begin
            if (cycles == 1000 * count)
                stop_run("timeout waiting for a complete TM1638 display write");
            @(posedge clk);
            cycles++;
        end
        #1;
    endtask

    task automatic wait_mic_frames(input int count);
        int target;
        int cycles;
        target = mic_frames + count;
        cycles = 0;
        while (mic_frames < target)
        begin
            if (cycles == 100 * count)
                stop_run("timeout waiting for the microphone SPI frame to end");
            @(posedge clk);
            cycles++;
        end
        #1;
    endtask

    initial
    begin
        seed        = $urandom(29729);
        arst_n      = 1'b0;
        key         = '0;
        sw          = '0;
        md_oe       = 1'b0;
        md_val      = 1'b0;
        cur_byte    = '0;
        frame_bits  = 0;
        frame_cmd   = cmd_write_auto;
        image_count = 0;
        tm_keys     = '0;
        mic_sample  = '0;
        mic_sdo     = 1'b0;
        mic_bit     = 0;
        mic_frames  = 0;
        step_cycles(10);

        // idle bus levels while reset is held
        check_pin("reset_sio_stb", 1'b1, tm_sio_stb);
        check_pin("reset_sio_clk", 1'b1, tm_sio_clk);
        check_pin("reset_sio_data", 1'b0, tm_sio_data);
        check_pin("reset_mic_cs", 1'b1, mic_cs);
        check_leds("reset_leds", '0, led);
        arst_n = 1'b1;

        // the first refresh after reset
        wait_cmds(4);
        check_cmd("first_cmd", cmd_write_auto, cmd_log[0]);
        check_cmd("second_cmd", cmd_addr_zero, cmd_log[1]);
        check_cmd("third_cmd", cmd_display_on, cmd_log[2]);
        check_cmd("fourth_cmd", cmd_read_keys, cmd_log[3]);
        check_image("reset_image", expected_image('0, 4'd0, image[14][0]), image);

        for (int i = 0; i < 6; i++)
        begin
            sw_val = w_sw'($urandom);
            sw     = sw_val;
            step_cycles(2);
            check_leds("switches", w_led'(sw_val), led);
        end

        for (int i = 0; i < 4; i++)
        begin
            cur_sample = w_mic'($urandom);
            cur_idx    = 4'($urandom % w_key);
            mic_sample = cur_sample;
            wait_mic_frames(2);  // a whole frame with the new sample
            key = w_key'(1) << cur_idx;
            step_cycles(3);
            key = '0;
            wait_refreshes(2);
            check_image("board_key", expected_image(cur_sample, cur_idx, image[14][0]), image);
        end

        n       = $urandom % w_tm_key;
        cur_idx = 4'(w_key + n);  // module keys sit above the board keys
        tm_keys = w_tm_key'(1) << n;
        wait_refreshes(3);
        tm_keys = '0;
        check_image("module_key", expected_image(cur_sample, cur_idx, image[14][0]), image);

        seen_dp0 = 1'b0;
        seen_dp1 = 1'b0;
        n        = 0;
        while (!(seen_dp0 && seen_dp1))
        begin
            if (n == 24)
                stop_run("digit 7 decimal point did not take both values in 24 refreshes");
            wait_refreshes(1);
            check_image("blink", expected_image(cur_sample, cur_idx, image[14][0]), image);
            if (image[14][0])
                seen_dp1 = 1'b1;
            else
                seen_dp0 = 1'b1;
            n++;
        end

        $display("all tests passed");
        $finish;
    end

endmodule
